//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dbg_console
FILELIST  ?= dbg_console.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= test passed
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dbg_console.f
design/dbg_pkg.sv
design/byte_scan.sv
design/byte_print.sv
design/dbg_dispatch.sv
design/cmd_mem_dump.sv
design/cmd_reg_dump.sv
design/dbg_console.sv
verification/tb_clk_gen.sv
verification/tb_dbg_console.sv

//--- design/byte_print.sv
`timescale 1ns/1ps

module byte_print
    import dbg_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  print_req_t print_req,
    output logic       print_ack,
    output byte_t      tx_data,
    output logic       tx_vld,
    input  logic       tx_rdy
);

    logic [3:0] cnt_q;
    word_t      shreg_q;
    logic       start;
    logic       xfer;

    // nibble to upper-case ascii
    function automatic byte_t hex_chr(input logic [3:0] nib);
        if (nib < 4'd10)
            return 8'h30 + {4'h0, nib};
        else
            return 8'h37 + {4'h0, nib};
    endfunction

    assign start = print_req.req & ~print_ack & ~tx_vld;
    assign xfer  = tx_vld & tx_rdy;

    ////////////////////
    // control
    ////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            tx_vld    <= 1'b0;
            print_ack <= 1'b0;
            cnt_q     <= 4'd0;
        end
        else if (start)
        begin
            tx_vld <= 1'b1;
            // bytes left after the first one: 7 digits plus lf
            cnt_q  <= (print_req.kind == print_word) ? 4'd8 : 4'd0;
        end
        else if (xfer)
        begin
            if (cnt_q == 4'd0)
            begin
                tx_vld    <= 1'b0;
                print_ack <= 1'b1;
            end
            else
                cnt_q <= cnt_q - 4'd1;
        end
        else if (print_ack && !print_req.req)
            print_ack <= 1'b0;
    end

    // output byte and digit shifter
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            if (print_req.kind == print_word)
            begin
                tx_data <= hex_chr(print_req.value[31:28]);
                shreg_q <= {print_req.value[27:0], 4'h0};
            end
            else
                tx_data <= print_req.value[7:0];
        end
        else if (xfer && cnt_q != 4'd0)
        begin
            if (cnt_q == 4'd1)
                tx_data <= chr_lf;
            else
            begin
                tx_data <= hex_chr(shreg_q[31:28]);
                shreg_q <= {shreg_q[27:0], 4'h0};
            end
        end
    end

endmodule

//--- design/byte_scan.sv
`timescale 1ns/1ps

module byte_scan
    import dbg_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  byte_t     rx_data,
    input  logic      rx_vld,
    output logic      rx_rdy,
    input  scan_req_t scan_req,
    output scan_rsp_t scan_rsp
);

    logic       ack_q;
    logic       seen_q;
    word_t      acc_q;
    logic       hex_ok;
    logic [3:0] hex_val;

    // ready only while a request is open and not yet answered
    assign rx_rdy = scan_req.req & ~ack_q;

    assign scan_rsp.ack   = ack_q;
    assign scan_rsp.value = acc_q;

    // hex digit decode, either case
    always_comb
    begin
        hex_ok  = 1'b1;
        hex_val = 4'h0;
        if (rx_data >= "0" && rx_data <= "9")
            hex_val = rx_data[3:0];
        else if ((rx_data >= "A" && rx_data <= "F") || (rx_data >= "a" && rx_data <= "f"))
            // 'A' and 'a' both end in nibble 1
            hex_val = rx_data[3:0] + 4'd9;
        else
            hex_ok = 1'b0;
    end

    ////////////////////
    // byte collection
    ////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            ack_q  <= 1'b0;
            seen_q <= 1'b0;
            acc_q  <= '0;
        end
        else if (!scan_req.req)
        begin
            // request gone, drop ack and start clean
            ack_q  <= 1'b0;
            seen_q <= 1'b0;
            acc_q  <= '0;
        end
        else if (rx_vld && rx_rdy)
        begin
            if (scan_req.kind == scan_char)
            begin
                acc_q <= word_t'(rx_data);
                ack_q <= 1'b1;
            end
            else if (hex_ok)
            begin
                // shift in next digit
                acc_q  <= {acc_q[27:0], hex_val};
                seen_q <= 1'b1;
            end
            else if (seen_q || rx_data != chr_space)
                // first non-hex byte ends the word, byte is dropped
                ack_q <= 1'b1;
        end
    end

endmodule

//--- design/cmd_mem_dump.sv
`timescale 1ns/1ps

module cmd_mem_dump
    import dbg_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       start,
    output logic       done,
    output scan_req_t  scan_req,
    input  scan_rsp_t  scan_rsp,
    output print_req_t print_req,
    input  logic       print_ack,
    output word_t      dm_addr,
    input  word_t      dm_data
);

    typedef enum logic [2:0] {
        m_idle,
        m_scan,
        m_scan_rel,
        m_read,
        m_print,
        m_print_rel
    } mem_state_e;

    mem_state_e state_q;
    logic [2:0] cnt_q;
    word_t      addr_q;
    word_t      data_q;
    logic       last;

    assign dm_addr = addr_q;
    assign last    = (int'(cnt_q) == dump_words - 1);
    assign done    = (state_q == m_print_rel) & ~print_ack & last;

    assign scan_req.req    = (state_q == m_scan);
    assign scan_req.kind   = scan_word;
    assign print_req.req   = (state_q == m_print);
    assign print_req.kind  = print_word;
    assign print_req.value = data_q;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state_q <= m_idle;
            cnt_q   <= '0;
        end
        else
        begin
            case (state_q)
                m_idle:
                    if (start)
                        state_q <= m_scan;
                m_scan:
                    if (scan_rsp.ack)
                        state_q <= m_scan_rel;
                m_scan_rel:
                    if (!scan_rsp.ack)
                    begin
                        cnt_q   <= '0;
                        state_q <= m_read;
                    end
                m_read:
                    state_q <= m_print;
                m_print:
                    if (print_ack)
                        state_q <= m_print_rel;
                m_print_rel:
                    if (!print_ack)
                    begin
                        cnt_q   <= cnt_q + 3'd1;
                        state_q <= last ? m_idle : m_read;
                    end
                default:
                    state_q <= m_idle;
            endcase
        end
    end

    // base address, then step by one word
    always_ff @(posedge clk)
    begin
        if (state_q == m_scan && scan_rsp.ack)
            addr_q <= scan_rsp.value;
        else if (state_q == m_print_rel && !print_ack)
            addr_q <= addr_q + 32'd4;
        if (state_q == m_read)
            data_q <= dm_data;
    end

endmodule

//--- design/cmd_reg_dump.sv
`timescale 1ns/1ps

module cmd_reg_dump
    import dbg_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       start,
    output logic       done,
    output print_req_t print_req,
    input  logic       print_ack,
    output reg_idx_t   rf_addr,
    input  word_t      rf_data
);

    typedef enum logic [1:0] {
        r_idle,
        r_read,
        r_print,
        r_release
    } reg_state_e;

    reg_state_e state_q;
    reg_idx_t   idx_q;
    word_t      data_q;
    logic       last;

    assign rf_addr = idx_q;
    assign last    = (int'(idx_q) == num_regs - 1);
    assign done    = (state_q == r_release) & ~print_ack & last;

    assign print_req.req   = (state_q == r_print);
    assign print_req.kind  = print_word;
    assign print_req.value = data_q;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state_q <= r_idle;
            idx_q   <= '0;
        end
        else
        begin
            case (state_q)
                r_idle:
                    if (start)
                    begin
                        idx_q   <= '0;
                        state_q <= r_read;
                    end
                r_read:
                    state_q <= r_print;
                r_print:
                    if (print_ack)
                        state_q <= r_release;
                r_release:
                    // next register once the printer lets go
                    if (!print_ack)
                    begin
                        idx_q   <= idx_q + 5'd1;
                        state_q <= last ? r_idle : r_read;
                    end
                default:
                    state_q <= r_idle;
            endcase
        end
    end

    // capture one cycle after idx is set
    always_ff @(posedge clk)
    begin
        if (state_q == r_read)
            data_q <= rf_data;
    end

endmodule

//--- design/dbg_console.sv
`timescale 1ns/1ps

module dbg_console
    import dbg_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  byte_t    rx_data,
    input  logic     rx_vld,
    output logic     rx_rdy,
    output byte_t    tx_data,
    output logic     tx_vld,
    input  logic     tx_rdy,
    output reg_idx_t rf_addr,
    input  word_t    rf_data,
    output word_t    dm_addr,
    input  word_t    dm_data
);

    // scanner and printer side
    scan_req_t  scan_req;
    scan_rsp_t  scan_rsp;
    print_req_t print_req;
    logic       print_ack;

    // handler side
    scan_req_t  mem_scan_req;
    scan_rsp_t  mem_scan_rsp;
    print_req_t mem_print_req;
    print_req_t reg_print_req;
    logic       mem_print_ack;
    logic       reg_print_ack;
    logic       mem_start;
    logic       mem_done;
    logic       reg_start;
    logic       reg_done;

    byte_scan u_byte_scan (
        .clk      (clk),
        .rstn     (rstn),
        .rx_data  (rx_data),
        .rx_vld   (rx_vld),
        .rx_rdy   (rx_rdy),
        .scan_req (scan_req),
        .scan_rsp (scan_rsp)
    );

    byte_print u_byte_print (
        .clk       (clk),
        .rstn      (rstn),
        .print_req (print_req),
        .print_ack (print_ack),
        .tx_data   (tx_data),
        .tx_vld    (tx_vld),
        .tx_rdy    (tx_rdy)
    );

    dbg_dispatch u_dbg_dispatch (
        .clk           (clk),
        .rstn          (rstn),
        .scan_req      (scan_req),
        .scan_rsp      (scan_rsp),
        .print_req     (print_req),
        .print_ack     (print_ack),
        .mem_scan_req  (mem_scan_req),
        .mem_scan_rsp  (mem_scan_rsp),
        .mem_print_req (mem_print_req),
        .mem_print_ack (mem_print_ack),
        .mem_done      (mem_done),
        .mem_start     (mem_start),
        .reg_print_req (reg_print_req),
        .reg_print_ack (reg_print_ack),
        .reg_done      (reg_done),
        .reg_start     (reg_start)
    );

    cmd_mem_dump u_cmd_mem_dump (
        .clk       (clk),
        .rstn      (rstn),
        .start     (mem_start),
        .done      (mem_done),
        .scan_req  (mem_scan_req),
        .scan_rsp  (mem_scan_rsp),
        .print_req (mem_print_req),
        .print_ack (mem_print_ack),
        .dm_addr   (dm_addr),
        .dm_data   (dm_data)
    );

    cmd_reg_dump u_cmd_reg_dump (
        .clk       (clk),
        .rstn      (rstn),
        .start     (reg_start),
        .done      (reg_done),
        .print_req (reg_print_req),
        .print_ack (reg_print_ack),
        .rf_addr   (rf_addr),
        .rf_data   (rf_data)
    );

endmodule

//--- design/dbg_dispatch.sv
`timescale 1ns/1ps

module dbg_dispatch
    import dbg_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    output scan_req_t  scan_req,
    input  scan_rsp_t  scan_rsp,
    output print_req_t print_req,
    input  logic       print_ack,
    input  scan_req_t  mem_scan_req,
    output scan_rsp_t  mem_scan_rsp,
    input  print_req_t mem_print_req,
    output logic       mem_print_ack,
    input  logic       mem_done,
    output logic       mem_start,
    input  print_req_t reg_print_req,
    output logic       reg_print_ack,
    input  logic       reg_done,
    output logic       reg_start
);

    dispatch_state_e state_q;
    cmd_sel_e        sel_q;
    logic            run_done;
    logic            released;

    // scanner ack gone, handler may take over
    assign released  = (state_q == st_release) & ~scan_rsp.ack;
    assign mem_start = released & (sel_q == sel_mem);
    assign reg_start = released & (sel_q == sel_reg);

    assign run_done = (sel_q == sel_mem) ? mem_done :
                      (sel_q == sel_reg) ? reg_done : 1'b0;

    ////////////////////
    // command FSM
    ////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state_q <= st_idle;
            sel_q   <= sel_none;
        end
        else
        begin
            case (state_q)
                st_idle:
                    state_q <= st_read_cmd;
                st_read_cmd:
                    if (scan_rsp.ack)
                    begin
                        state_q <= st_release;
                        case (scan_rsp.value[7:0])
                            chr_cmd_r: sel_q <= sel_reg;
                            chr_cmd_d: sel_q <= sel_mem;
                            // blanks, line ends and unknown letters
                            default: sel_q <= sel_none;
                        endcase
                    end
                st_release:
                    // unknown letter goes straight back for another
                    if (!scan_rsp.ack)
                        state_q <= (sel_q == sel_none) ? st_read_cmd : st_run;
                st_run:
                    if (run_done)
                    begin
                        state_q <= st_read_cmd;
                        sel_q   <= sel_none;
                    end
                default:
                    state_q <= st_idle;
            endcase
        end
    end

    ////////////////////
    // port routing
    ////////////////////
    always_comb
    begin
        scan_req      = '0;
        print_req     = '0;
        mem_scan_rsp  = '0;
        mem_print_ack = 1'b0;
        reg_print_ack = 1'b0;
        if (state_q == st_read_cmd)
        begin
            scan_req.req  = 1'b1;
            scan_req.kind = scan_char;
        end
        else if (state_q == st_run && sel_q == sel_mem)
        begin
            scan_req      = mem_scan_req;
            mem_scan_rsp  = scan_rsp;
            print_req     = mem_print_req;
            mem_print_ack = print_ack;
        end
        else if (state_q == st_run && sel_q == sel_reg)
        begin
            // register dump never scans
            print_req     = reg_print_req;
            reg_print_ack = print_ack;
        end
    end

endmodule

//--- design/dbg_pkg.sv
package dbg_pkg;

    ////////////////////
    // widths
    ////////////////////
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // dump sizes
    localparam int num_regs   = 32;
    localparam int dump_words = 8;

    // ascii codes seen on the console
    localparam byte_t chr_cmd_r = 8'h52;
    localparam byte_t chr_cmd_d = 8'h44;
    localparam byte_t chr_lf    = 8'h0A;
    localparam byte_t chr_cr    = 8'h0D;
    localparam byte_t chr_space = 8'h20;

    ////////////////////
    // scan port
    ////////////////////
    typedef enum logic {
        scan_char,
        scan_word
    } scan_kind_e;

    typedef struct packed {
        logic       req;
        scan_kind_e kind;
    } scan_req_t;

    // char result sits in the low byte
    typedef struct packed {
        logic  ack;
        word_t value;
    } scan_rsp_t;

    ////////////////////
    // print port
    ////////////////////
    typedef enum logic {
        print_char,
        print_word
    } print_kind_e;

    typedef struct packed {
        logic        req;
        print_kind_e kind;
        word_t       value;
    } print_req_t;

    ////////////////////
    // dispatcher
    ////////////////////
    typedef enum logic [1:0] {
        st_idle,
        st_read_cmd,
        st_release,
        st_run
    } dispatch_state_e;

    typedef enum logic [1:0] {
        sel_none,
        sel_reg,
        sel_mem
    } cmd_sel_e;

endpackage

//--- verification/dbg_console_stim.txt
# name kind base lines stall nbytes cmd
# cmd is the command in hex bytes, first byte sent leftmost
r_dump     R 0       32 0  2 520A
d_dump     D 100      8 0  6 44203130300A
d_spaces   D abcde0   8 0 13 4420202030306162634465300A
unknown_r  R 0       32 0  5 78510A520A
d_stalled  D 100      8 1  6 44203130300A

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk,
    output logic rstn
);

    // 20 ns period
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held low for 16 cycles
    initial
    begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

//--- verification/tb_dbg_console.sv
`timescale 1ns/1ps

module tb_dbg_console
    import dbg_pkg::*;
();

    localparam int max_recs = 16;

    logic     clk;
    logic     rstn;
    byte_t    rx_data;
    logic     rx_vld;
    logic     rx_rdy;
    byte_t    tx_data;
    logic     tx_vld;
    logic     tx_rdy;
    reg_idx_t rf_addr;
    word_t    rf_data;
    word_t    dm_addr;
    word_t    dm_data;

    // test records from the stim file
    logic [127:0] rec_name [max_recs];
    byte_t        rec_kind [max_recs];
    word_t        rec_base [max_recs];
    int           rec_lines [max_recs];
    int           rec_stall [max_recs];
    int           rec_nbytes [max_recs];
    logic [127:0] rec_cmd [max_recs];
    int           n_recs;

    // file reading scratch
    int            fd;
    int            nfield;
    logic [127:0]  name_v;
    byte_t         kind_v;
    word_t         base_v;
    int            lines_v;
    int            stall_v;
    int            nbytes_v;
    logic [127:0]  cmd_v;
    logic [1023:0] line_buf;

    int     errors;
    int     r;
    integer seed;
    logic   stall_en;

    tb_clk_gen u_tb_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    dbg_console u_dbg_console (
        .clk     (clk),
        .rstn    (rstn),
        .rx_data (rx_data),
        .rx_vld  (rx_vld),
        .rx_rdy  (rx_rdy),
        .tx_data (tx_data),
        .tx_vld  (tx_vld),
        .tx_rdy  (tx_rdy),
        .rf_addr (rf_addr),
        .rf_data (rf_data),
        .dm_addr (dm_addr),
        .dm_data (dm_data)
    );

    ////////////////////
    // memory models
    ////////////////////
    assign rf_data = ({27'd0, rf_addr} * 32'h01010101) ^ 32'hC0DE0000;
    assign dm_data = dm_addr ^ 32'h5A5A5A5A;

    // random output stalls, only for records that ask for them
    always @(posedge clk)
    begin
        if (stall_en)
            tx_rdy <= ($random(seed) & 3) != 0;
        else
            tx_rdy <= 1'b1;
    end

    // word expected on output line idx
    function automatic word_t expected_word(input byte_t kind, input word_t base, input int idx);
        word_t idx_w;
        idx_w = word_t'(idx);
        if (kind == chr_cmd_r)
            return (idx_w * 32'h01010101) ^ 32'hC0DE0000;
        else
            return (base + (idx_w << 2)) ^ 32'h5A5A5A5A;
    endfunction

    // bit 4 set for a valid upper-case digit
    function automatic logic [4:0] decode_hex_digit(input byte_t c);
        if (c >= 8'h30 && c <= 8'h39)
            return {1'b1, c[3:0]};
        else if (c >= 8'h41 && c <= 8'h46)
            return {1'b1, c[3:0] + 4'd9};
        else
            return 5'h00;
    endfunction

    ////////////////////
    // byte driver
    ////////////////////
    // first byte sits highest in cmd
    task automatic send_cmd(input logic [127:0] cmd, input int nbytes);
        int i;
        for (i = nbytes - 1; i >= 0; i--)
        begin
            rx_data <= cmd[i*8 +: 8];
            rx_vld  <= 1'b1;
            @(posedge clk);
            while (!rx_rdy)
                @(posedge clk);
        end
        rx_vld <= 1'b0;
    endtask

    ////////////////////
    // output checker
    ////////////////////
    task automatic check_lines(input int rec);
        int         got;
        int         nchr;
        word_t      value;
        word_t      exp;
        logic [4:0] dig;
        logic       bad;
        got   = 0;
        nchr  = 0;
        value = '0;
        bad   = 1'b0;
        while (got < rec_lines[rec])
        begin
            @(posedge clk);
            if (tx_vld && tx_rdy)
            begin
                if (tx_data == chr_lf)
                begin
                    exp = expected_word(rec_kind[rec], rec_base[rec], got);
                    if (nchr != 8 || bad)
                    begin
                        $display("%0s: line %0d is not eight upper-case hex digits",
                                 rec_name[rec], got);
                        errors++;
                    end
                    else if (value != exp)
                    begin
                        $display("[FAIL] %0s line %0d: expected %08h, actual %08h",
                                 rec_name[rec], got, exp, value);
                        errors++;
                    end
                    got++;
                    nchr  = 0;
                    value = '0;
                    bad   = 1'b0;
                end
                else
                begin
                    dig = decode_hex_digit(tx_data);
                    if (!dig[4])
                        bad = 1'b1;
                    value = {value[27:0], dig[3:0]};
                    nchr++;
                end
            end
        end
    endtask

    // nothing more may come out once all lines are in
    task automatic check_quiet(input int rec);
        int i;
        logic seen;
        seen = 1'b0;
        for (i = 0; i < 40; i++)
        begin
            @(posedge clk);
            if (tx_vld && !seen)
            begin
                $display("%0s: extra output after the last expected line", rec_name[rec]);
                errors++;
                seen = 1'b1;
            end
        end
    endtask

    // 200 us per record, plus reset
    task automatic watchdog(input int n);
        #(n * 200000 + 10000);
        $display("timeout: output lines missing, %0d errors so far", errors);
        $display("test failed");
        $finish;
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial
    begin
        rx_data  = 8'h00;
        rx_vld   = 1'b0;
        tx_rdy   = 1'b0;
        stall_en = 1'b0;
        errors   = 0;
        n_recs   = 0;
        seed     = 32'h287e0181;

        fd = $fopen("verification/dbg_console_stim.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                name_v = '0;
                nfield = $fscanf(fd, "%s", name_v);
                // lone # token starts a comment line
                if (nfield == 1 && name_v == 128'h23)
                    nfield = $fgets(line_buf, fd);
                else if (nfield == 1)
                begin
                    nfield = $fscanf(fd, "%s %h %d %d %d %h", kind_v, base_v, lines_v,
                                     stall_v, nbytes_v, cmd_v);
                    if (nfield == 6 && n_recs < max_recs)
                    begin
                        rec_name[n_recs]   = name_v;
                        rec_kind[n_recs]   = kind_v;
                        rec_base[n_recs]   = base_v;
                        rec_lines[n_recs]  = lines_v;
                        rec_stall[n_recs]  = stall_v;
                        rec_nbytes[n_recs] = nbytes_v;
                        rec_cmd[n_recs]    = cmd_v;
                        n_recs++;
                    end
                    else
                    begin
                        $display("stimulus record %0s is malformed or over the limit", name_v);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_recs == 0)
        begin
            $display("no test records could be read from the stimulus file");
            errors++;
        end
        else
        begin
            fork
                watchdog(n_recs);
            join_none
        end

        // outputs quiet through reset
        repeat (15)
        begin
            @(posedge clk);
            if (tx_vld || rx_rdy)
            begin
                $display("tx_vld or rx_rdy went high during reset");
                errors++;
            end
        end
        wait (rstn);
        @(posedge clk);

        // no output before any input
        repeat (10)
        begin
            @(posedge clk);
            if (tx_vld)
            begin
                $display("tx_vld went high before any input was sent");
                errors++;
            end
        end

        for (r = 0; r < n_recs; r++)
        begin
            stall_en <= (rec_stall[r] != 0);
            fork
                send_cmd(rec_cmd[r], rec_nbytes[r]);
                check_lines(r);
            join
            check_quiet(r);
        end

        $display("checks done: %0d records, %0d errors", n_recs, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
